// ==== logic/cluster_control_unit.sv ====
`default_nettype none
`include "cluster_periph_settings.svh"

module cluster_control_unit
  import cluster_periph_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  req_i,
  input  wire logic [31:0]           add_i,
  input  wire logic                  wen_i,
  input  wire logic [31:0]           wdata_i,
  input  wire logic [3:0]            be_i,
  input  wire logic                  en_sa_boot_i,
  input  wire logic                  fetch_en_i,
  output logic [31:0]                rdata_o,
  output logic                       eoc_o,
  output logic [`NB_CORES-1:0]       fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0] boot_addr_o
);

  localparam int CORE_BITS = $clog2(`NB_CORES);

  logic [7:0]                 offs;
  logic                       wr;
  logic                       rd;
  logic                       boot_hit;
  logic [CORE_BITS-1:0]       core_idx;
  logic                       eoc_q;
  logic [`NB_CORES-1:0]       fetch_q;
  logic [`NB_CORES-1:0][31:0] boot_q;
  logic [31:0]                rd_val;
  logic [31:0]                rdata_q;

  assign offs     = add_i[7:0];
  assign wr       = req_i && !wen_i;
  assign rd       = req_i && wen_i;
  assign boot_hit = (offs >= CTRL_BOOT_BASE) && (offs < CTRL_BOOT_BASE + 4 * `NB_CORES);
  assign core_idx = add_i[2 +: CORE_BITS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q   <= 1'b0;
      fetch_q <= '0;
      // Stand-alone boot starts from ROM
      for (int c = 0; c < `NB_CORES; c++) begin
        boot_q[c] <= en_sa_boot_i ? `ROM_BOOT_ADDR : `BOOT_ADDR;
      end
    end else if (wr) begin
      if (boot_hit) begin
        boot_q[core_idx] <= be_merge(boot_q[core_idx], wdata_i, be_i);
      end else if (offs == CTRL_EOC && be_i[0]) begin
        eoc_q <= wdata_i[0];
      end else if (offs == CTRL_FETCH_EN && be_i[0]) begin
        fetch_q <= wdata_i[`NB_CORES-1:0];
      end
    end
  end

  always_comb begin
    rd_val = 32'h0;
    if (boot_hit) begin
      rd_val = boot_q[core_idx];
    end else if (offs == CTRL_EOC) begin
      rd_val = 32'(eoc_q);
    end else if (offs == CTRL_FETCH_EN) begin
      rd_val = 32'(fetch_q);
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    rdata_q <= rd ? rd_val : 32'h0;
  end

  assign rdata_o        = rdata_q;
  assign eoc_o          = eoc_q;
  assign boot_addr_o    = boot_q;
  assign fetch_enable_o = fetch_q & {`NB_CORES{fetch_en_i}};

endmodule

`default_nettype wire

// ==== logic/cluster_periph_pkg.sv ====
`default_nettype none

package cluster_periph_pkg;

  // Peripheral slot, taken from address bits 11:10
  typedef enum logic [1:0] {
    SLOT_CTRL  = 2'd0,
    SLOT_TIMER = 2'd1,
    SLOT_EU    = 2'd2,
    SLOT_NONE  = 2'd3
  } periph_slot_e;

  // Control unit offsets, boot addresses follow at 4 byte steps
  typedef enum logic [7:0] {
    CTRL_EOC       = 8'h00,
    CTRL_FETCH_EN  = 8'h08,
    CTRL_BOOT_BASE = 8'h40
  } ctrl_reg_e;

  typedef enum logic [3:0] {
    TIMER_CFG   = 4'h0,
    TIMER_COUNT = 4'h4,
    TIMER_CMP   = 4'h8
  } timer_reg_e;

  // Per-core group offsets plus one global register
  typedef enum logic [7:0] {
    EU_MASK     = 8'h00,
    EU_BUFFER   = 8'h04,
    EU_CLEAR    = 8'h08,
    EU_SLEEP    = 8'h0C,
    EU_SOC_DATA = 8'h80
  } eu_reg_e;

  typedef enum logic {
    CORE_RUN   = 1'b0,
    CORE_SLEEP = 1'b1
  } core_state_e;

  // Byte-enable merge of a write into a 32-bit register
  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== logic/cluster_periph_settings.svh ====
`ifndef CLUSTER_PERIPH_SETTINGS_SVH
`define CLUSTER_PERIPH_SETTINGS_SVH

// Cluster size and bus id width (one-hot over cores plus one master)
`define NB_CORES        4
`define PER_ID_WIDTH    5

// Boot addresses loaded at reset
`define BOOT_ADDR       32'h1C00_0000
`define ROM_BOOT_ADDR   32'h1A00_0000

// Address map
`define PERIPH_SLOT_MSB 11
`define PERIPH_SLOT_LSB 10
`define ERR_RDATA       32'hDEAD_B33F
`define EU_CORE_STRIDE  16

// Event lines seen by every core
`define NB_EVT          3
`define EVT_TIMER_BIT   0
`define EVT_DMA_BIT     1
`define EVT_SOC_BIT     2
`define SOC_EVT_WIDTH   8

`endif

// ==== logic/cluster_peripherals.sv ====
`default_nettype none
`include "cluster_periph_settings.svh"

module cluster_peripherals (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      req_i,
  input  wire logic [31:0]               add_i,
  input  wire logic                      wen_i,
  input  wire logic [31:0]               wdata_i,
  input  wire logic [3:0]                be_i,
  input  wire logic [`PER_ID_WIDTH-1:0]  id_i,
  output logic                           gnt_o,
  output logic                           r_valid_o,
  output logic [31:0]                    r_rdata_o,
  output logic [`PER_ID_WIDTH-1:0]       r_id_o,
  input  wire logic                      en_sa_boot_i,
  input  wire logic                      fetch_en_i,
  input  wire logic [`NB_CORES-1:0]      dma_evt_i,
  input  wire logic                      soc_evt_valid_i,
  input  wire logic [`SOC_EVT_WIDTH-1:0] soc_evt_data_i,
  output logic                           soc_evt_ready_o,
  output logic                           eoc_o,
  output logic [`NB_CORES-1:0]           fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0]     boot_addr_o,
  output logic [`NB_CORES-1:0]           core_clk_en_o,
  output logic                           busy_o
);

  logic        ctrl_req;
  logic        timer_req;
  logic        eu_req;
  logic [31:0] per_add;
  logic        per_wen;
  logic [31:0] per_wdata;
  logic [3:0]  per_be;
  logic [31:0] ctrl_rdata;
  logic [31:0] timer_rdata;
  logic [31:0] eu_rdata;
  logic        timer_evt;

  //************************************************************
  //******************** Bus demux *****************************
  //************************************************************
  periph_bus_demux i_periph_bus_demux (
    .clk_i, .rst_n_i, .req_i, .add_i, .wen_i, .wdata_i, .be_i, .id_i,
    .gnt_o, .r_valid_o, .r_rdata_o, .r_id_o,
    .ctrl_req_o    ( ctrl_req    ),
    .timer_req_o   ( timer_req   ),
    .eu_req_o      ( eu_req      ),
    .add_o         ( per_add     ),
    .wen_o         ( per_wen     ),
    .wdata_o       ( per_wdata   ),
    .be_o          ( per_be      ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .eu_rdata_i    ( eu_rdata    )
  );

  //************************************************************
  //******************** Peripherals ***************************
  //************************************************************
  cluster_control_unit i_cluster_control_unit (
    .clk_i, .rst_n_i,
    .req_i   ( ctrl_req  ),
    .add_i   ( per_add   ),
    .wen_i   ( per_wen   ),
    .wdata_i ( per_wdata ),
    .be_i    ( per_be    ),
    .en_sa_boot_i, .fetch_en_i,
    .rdata_o ( ctrl_rdata ),
    .eoc_o, .fetch_enable_o, .boot_addr_o
  );

  cluster_timer i_cluster_timer (
    .clk_i, .rst_n_i,
    .req_i   ( timer_req   ),
    .add_i   ( per_add     ),
    .wen_i   ( per_wen     ),
    .wdata_i ( per_wdata   ),
    .be_i    ( per_be      ),
    .rdata_o ( timer_rdata ),
    .evt_o   ( timer_evt   ),
    .busy_o
  );

  event_unit i_event_unit (
    .clk_i, .rst_n_i,
    .req_i       ( eu_req    ),
    .add_i       ( per_add   ),
    .wen_i       ( per_wen   ),
    .wdata_i     ( per_wdata ),
    .be_i        ( per_be    ),
    .timer_evt_i ( timer_evt ),
    .dma_evt_i, .soc_evt_valid_i, .soc_evt_data_i, .soc_evt_ready_o,
    .rdata_o     ( eu_rdata  ),
    .core_clk_en_o
  );

endmodule

`default_nettype wire

// ==== logic/cluster_timer.sv ====
`default_nettype none

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        req_i,
  input  wire logic [31:0] add_i,
  input  wire logic        wen_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  be_i,
  output logic [31:0]      rdata_o,
  output logic             evt_o,
  output logic             busy_o
);

  timer_reg_e  reg_sel;
  logic        wr;
  logic        rd;
  logic        tick;
  logic        en_q;
  logic [3:0]  presc_q;
  logic [3:0]  presc_cnt_q;
  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic        evt_q;
  logic [31:0] rd_val;
  logic [31:0] rdata_q;

  assign reg_sel = timer_reg_e'(add_i[3:0]);
  assign wr      = req_i && !wen_i;
  assign rd      = req_i && wen_i;

  // One increment every presc+1 cycles
  assign tick = en_q && (presc_cnt_q == presc_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q        <= 1'b0;
      presc_q     <= 4'd0;
      presc_cnt_q <= 4'd0;
      count_q     <= 32'd0;
      cmp_q       <= 32'd0;
      evt_q       <= 1'b0;
    end else begin
      evt_q <= 1'b0;
      if (tick) begin
        presc_cnt_q <= 4'd0;
        // Wrap on match and flag the event
        if (count_q == cmp_q) begin
          count_q <= 32'd0;
          evt_q   <= 1'b1;
        end else begin
          count_q <= count_q + 32'd1;
        end
      end else if (en_q) begin
        presc_cnt_q <= presc_cnt_q + 4'd1;
      end

      if (wr) begin
        case (reg_sel)
          TIMER_CFG: begin
            if (be_i[0]) begin
              en_q    <= wdata_i[0];
              presc_q <= wdata_i[7:4];
            end
            presc_cnt_q <= 4'd0;
          end
          TIMER_COUNT: count_q <= be_merge(count_q, wdata_i, be_i);
          TIMER_CMP:   cmp_q   <= be_merge(cmp_q, wdata_i, be_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_sel)
      TIMER_CFG:   rd_val = {24'h0, presc_q, 3'b000, en_q};
      TIMER_COUNT: rd_val = count_q;
      TIMER_CMP:   rd_val = cmp_q;
      default:     rd_val = 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rd ? rd_val : 32'h0;
  end

  assign rdata_o = rdata_q;
  assign evt_o   = evt_q;
  assign busy_o  = en_q;

endmodule

`default_nettype wire

// ==== logic/event_unit.sv ====
`default_nettype none
`include "cluster_periph_settings.svh"

module event_unit
  import cluster_periph_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      req_i,
  input  wire logic [31:0]               add_i,
  input  wire logic                      wen_i,
  input  wire logic [31:0]               wdata_i,
  input  wire logic [3:0]                be_i,
  input  wire logic                      timer_evt_i,
  input  wire logic [`NB_CORES-1:0]      dma_evt_i,
  input  wire logic                      soc_evt_valid_i,
  input  wire logic [`SOC_EVT_WIDTH-1:0] soc_evt_data_i,
  output logic                           soc_evt_ready_o,
  output logic [31:0]                    rdata_o,
  output logic [`NB_CORES-1:0]           core_clk_en_o
);

  localparam int CORE_BITS   = $clog2(`NB_CORES);
  localparam int STRIDE_BITS = $clog2(`EU_CORE_STRIDE);

  logic                               wr;
  logic                               rd;
  logic                               core_hit;
  logic [CORE_BITS-1:0]               core_idx;
  eu_reg_e                            reg_sel;
  logic                               soc_fire;
  logic                               soc_ready_q;
  logic [`SOC_EVT_WIDTH-1:0]          soc_data_q;
  logic [`NB_CORES-1:0][`NB_EVT-1:0]  evt_in;
  logic [`NB_CORES-1:0][`NB_EVT-1:0]  mask_q;
  logic [`NB_CORES-1:0][`NB_EVT-1:0]  buf_q;
  core_state_e                        state_q [`NB_CORES];
  logic [`NB_CORES-1:0]               wr_core;
  logic [`NB_CORES-1:0]               wake;
  logic [31:0]                        rd_val;
  logic [31:0]                        rdata_q;

  assign wr       = req_i && !wen_i;
  assign rd       = req_i && wen_i;
  assign core_hit = add_i[7:0] < `NB_CORES * `EU_CORE_STRIDE;
  assign core_idx = add_i[STRIDE_BITS +: CORE_BITS];
  assign reg_sel  = eu_reg_e'(8'(add_i[STRIDE_BITS-1:0]));

  assign soc_fire        = soc_evt_valid_i && soc_ready_q;
  assign soc_evt_ready_o = soc_ready_q;

  for (genvar c = 0; c < `NB_CORES; c++) begin : g_core
    assign evt_in[c][`EVT_TIMER_BIT] = timer_evt_i;
    assign evt_in[c][`EVT_DMA_BIT]   = dma_evt_i[c];
    assign evt_in[c][`EVT_SOC_BIT]   = soc_fire;
    // All per-core fields live in the low byte
    assign wr_core[c]       = wr && be_i[0] && core_hit && (core_idx == c);
    assign wake[c]          = |(buf_q[c] & mask_q[c]);
    assign core_clk_en_o[c] = (state_q[c] == CORE_RUN);
  end

  //************************************************************
  //***************** Buffers, masks and sleep *****************
  //************************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q      <= '0;
      buf_q       <= '0;
      soc_ready_q <= 1'b1;
      for (int c = 0; c < `NB_CORES; c++) begin
        state_q[c] <= CORE_RUN;
      end
    end else begin
      // Drop ready for one cycle after each accepted SoC event
      soc_ready_q <= !soc_fire;
      for (int c = 0; c < `NB_CORES; c++) begin
        if (wr_core[c] && reg_sel == EU_MASK) begin
          mask_q[c] <= wdata_i[`NB_EVT-1:0];
        end
        // New events win over a clear in the same cycle
        if (wr_core[c] && reg_sel == EU_CLEAR) begin
          buf_q[c] <= (buf_q[c] & ~wdata_i[`NB_EVT-1:0]) | evt_in[c];
        end else begin
          buf_q[c] <= buf_q[c] | evt_in[c];
        end
        case (state_q[c])
          CORE_RUN: begin
            if (wr_core[c] && reg_sel == EU_SLEEP && !wake[c]) begin
              state_q[c] <= CORE_SLEEP;
            end
          end
          CORE_SLEEP: begin
            if (wake[c]) begin
              state_q[c] <= CORE_RUN;
            end
          end
          default: state_q[c] <= CORE_RUN;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (soc_fire) begin
      soc_data_q <= soc_evt_data_i;
    end
  end

  always_comb begin
    rd_val = 32'h0;
    if (add_i[7:0] == EU_SOC_DATA) begin
      rd_val = 32'(soc_data_q);
    end else if (core_hit) begin
      case (reg_sel)
        EU_MASK:   rd_val = 32'(mask_q[core_idx]);
        EU_BUFFER: rd_val = 32'(buf_q[core_idx]);
        EU_SLEEP:  rd_val = 32'(state_q[core_idx] == CORE_SLEEP);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rd ? rd_val : 32'h0;
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/periph_bus_demux.sv ====
`default_nettype none
`include "cluster_periph_settings.svh"

module periph_bus_demux
  import cluster_periph_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic                     req_i,
  input  wire logic [31:0]              add_i,
  input  wire logic                     wen_i,
  input  wire logic [31:0]              wdata_i,
  input  wire logic [3:0]               be_i,
  input  wire logic [`PER_ID_WIDTH-1:0] id_i,
  output logic                          gnt_o,
  output logic                          r_valid_o,
  output logic [31:0]                   r_rdata_o,
  output logic [`PER_ID_WIDTH-1:0]      r_id_o,
  output logic                          ctrl_req_o,
  output logic                          timer_req_o,
  output logic                          eu_req_o,
  output logic [31:0]                   add_o,
  output logic                          wen_o,
  output logic [31:0]                   wdata_o,
  output logic [3:0]                    be_o,
  input  wire logic [31:0]              ctrl_rdata_i,
  input  wire logic [31:0]              timer_rdata_i,
  input  wire logic [31:0]              eu_rdata_i
);

  periph_slot_e             slot;
  periph_slot_e             slot_q;
  logic [`PER_ID_WIDTH-1:0] id_q;
  logic                     valid_q;

  assign slot  = periph_slot_e'(add_i[`PERIPH_SLOT_MSB:`PERIPH_SLOT_LSB]);

  // Every slot accepts in the same cycle
  assign gnt_o = req_i;

  assign ctrl_req_o  = req_i && (slot == SLOT_CTRL);
  assign timer_req_o = req_i && (slot == SLOT_TIMER);
  assign eu_req_o    = req_i && (slot == SLOT_EU);

  // Shared address and write data bundle
  assign add_o   = add_i;
  assign wen_o   = wen_i;
  assign wdata_o = wdata_i;
  assign be_o    = be_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
    end
  end

  // Remember where the response has to come from
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      slot_q <= slot;
      id_q   <= id_i;
    end
  end

  assign r_valid_o = valid_q;
  assign r_id_o    = id_q;

  always_comb begin
    case (slot_q)
      SLOT_CTRL:  r_rdata_o = ctrl_rdata_i;
      SLOT_TIMER: r_rdata_o = timer_rdata_i;
      SLOT_EU:    r_rdata_o = eu_rdata_i;
      default:    r_rdata_o = `ERR_RDATA;
    endcase
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/cluster_periph_pkg.sv
logic/periph_bus_demux.sv
logic/cluster_control_unit.sv
logic/cluster_timer.sv
logic/event_unit.sv
logic/cluster_peripherals.sv
testbench/tb_clock_gen.sv
testbench/tb_cluster_peripherals.sv

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // Period of 4 time units
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_cluster_peripherals.sv ====
`default_nettype none
`include "cluster_periph_settings.svh"

module tb_cluster_peripherals
  import cluster_periph_pkg::*;
;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 10;
  localparam int BUS_CYCLES     = 2;
  localparam int NB_ACCESSES    = 90;
  localparam int MAX_TIMER_WAIT = (8 + 1) * (3 + 1) + 4;
  localparam int TEST_CYCLES    = RESET_CYCLES + NB_ACCESSES * BUS_CYCLES + MAX_TIMER_WAIT + 40;

  logic                       clk;
  logic                       rst_n;
  logic                       req;
  logic [31:0]                add;
  logic                       wen;
  logic [31:0]                wdata;
  logic [3:0]                 be;
  logic [`PER_ID_WIDTH-1:0]   id;
  logic                       gnt;
  logic                       r_valid;
  logic [31:0]                r_rdata;
  logic [`PER_ID_WIDTH-1:0]   r_id;
  logic                       en_sa_boot;
  logic                       fetch_en;
  logic [`NB_CORES-1:0]       dma_evt;
  logic                       soc_evt_valid;
  logic [`SOC_EVT_WIDTH-1:0]  soc_evt_data;
  logic                       soc_evt_ready;
  logic                       eoc;
  logic [`NB_CORES-1:0]       fetch_enable;
  logic [`NB_CORES-1:0][31:0] boot_addr;
  logic [`NB_CORES-1:0]       core_clk_en;
  logic                       busy;

  string       test_name = "setup";
  logic [31:0] lcg_state = 32'd2;
  int unsigned cycle_cnt = 0;
  int unsigned xfer_cycle;
  logic [31:0] boot_model [`NB_CORES];

  tb_clock_gen i_tb_clock_gen (
    .clk_o ( clk )
  );

  cluster_peripherals i_cluster_peripherals (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .req_i           ( req           ),
    .add_i           ( add           ),
    .wen_i           ( wen           ),
    .wdata_i         ( wdata         ),
    .be_i            ( be            ),
    .id_i            ( id            ),
    .gnt_o           ( gnt           ),
    .r_valid_o       ( r_valid       ),
    .r_rdata_o       ( r_rdata       ),
    .r_id_o          ( r_id          ),
    .en_sa_boot_i    ( en_sa_boot    ),
    .fetch_en_i      ( fetch_en      ),
    .dma_evt_i       ( dma_evt       ),
    .soc_evt_valid_i ( soc_evt_valid ),
    .soc_evt_data_i  ( soc_evt_data  ),
    .soc_evt_ready_o ( soc_evt_ready ),
    .eoc_o           ( eoc           ),
    .fetch_enable_o  ( fetch_enable  ),
    .boot_addr_o     ( boot_addr     ),
    .core_clk_en_o   ( core_clk_en   ),
    .busy_o          ( busy          )
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //************************************************************
  //******************* Helpers and checks *********************
  //************************************************************
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s (%s): expected 0x%08h, actual 0x%08h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_mask(input string what, input logic [`NB_CORES-1:0] exp,
                            input logic [`NB_CORES-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
                          test_name, what, exp, act));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // One-hot over the cores plus the master
  function automatic logic [`PER_ID_WIDTH-1:0] random_id();
    return `PER_ID_WIDTH'(1) << (lcg_next() % `PER_ID_WIDTH);
  endfunction

  function automatic logic [31:0] periph_addr(input periph_slot_e slot, input logic [7:0] offs);
    return {20'h10200, slot, 2'b00, offs};
  endfunction

  function automatic logic [31:0] eu_core_addr(input int core, input eu_reg_e r);
    return periph_addr(SLOT_EU, 8'(core * `EU_CORE_STRIDE) + 8'(r));
  endfunction

  function automatic logic [31:0] boot_reg_addr(input int core);
    return periph_addr(SLOT_CTRL, 8'(CTRL_BOOT_BASE) + 8'(4 * core));
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] m;
    m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~m) | (new_val & m);
  endfunction

  // Single transfer, response must follow exactly one cycle later
  task automatic bus_transfer(input logic is_read, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              output logic [31:0] rdata);
    logic [`PER_ID_WIDTH-1:0] req_id;
    req_id = random_id();
    @(posedge clk);
    req   <= 1'b1;
    add   <= addr;
    wen   <= is_read;
    wdata <= data;
    be    <= strb;
    id    <= req_id;
    @(negedge clk);
    check_word("grant", 32'(1'b1), 32'(gnt));
    check_word("no early response", 32'(1'b0), 32'(r_valid));
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    xfer_cycle = cycle_cnt;
    check_word("response valid", 32'(1'b1), 32'(r_valid));
    check_word("response id", 32'(req_id), 32'(r_id));
    rdata = r_rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rdata;
    bus_transfer(1'b0, addr, data, strb, rdata);
    check_word("write response data", 32'h0, rdata);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_transfer(1'b1, addr, 32'h0, 4'hF, rdata);
  endtask

  //************************************************************
  //************************ Tests *****************************
  //************************************************************
  task automatic test_reset_state();
    logic [31:0] rdata;
    test_name = "reset_state";
    check_word("eoc_o", 32'(1'b0), 32'(eoc));
    check_mask("fetch_enable_o", '0, fetch_enable);
    check_mask("core_clk_en_o", '1, core_clk_en);
    for (int c = 0; c < `NB_CORES; c++) begin
      boot_model[c] = `BOOT_ADDR;
      check_word("boot_addr_o", `BOOT_ADDR, boot_addr[c]);
      bus_read(boot_reg_addr(c), rdata);
      check_word("boot address read", `BOOT_ADDR, rdata);
    end
  endtask

  task automatic test_control_regs();
    logic [31:0]          rdata;
    logic [31:0]          data;
    logic [3:0]           strb;
    logic [`NB_CORES-1:0] fmask;
    test_name = "control_regs";
    for (int c = 0; c < `NB_CORES; c++) begin
      data = lcg_next();
      strb = lcg_next() % 15;
      // Keep the byte enables partial
      if (strb == 4'h0) begin
        strb = 4'b0101;
      end
      bus_write(boot_reg_addr(c), data, strb);
      boot_model[c] = byte_merge(boot_model[c], data, strb);
      check_word("boot_addr_o", boot_model[c], boot_addr[c]);
      bus_read(boot_reg_addr(c), rdata);
      check_word("boot address read", boot_model[c], rdata);
    end
    fmask = `NB_CORES'(lcg_next()) | `NB_CORES'(1);
    bus_write(periph_addr(SLOT_CTRL, CTRL_FETCH_EN), 32'(fmask), 4'h1);
    check_mask("fetch gated off", '0, fetch_enable);
    @(posedge clk);
    fetch_en <= 1'b1;
    @(negedge clk);
    check_mask("fetch gated on", fmask, fetch_enable);
    bus_read(periph_addr(SLOT_CTRL, CTRL_FETCH_EN), rdata);
    check_word("fetch mask read", 32'(fmask), rdata);
    @(posedge clk);
    fetch_en <= 1'b0;
    @(negedge clk);
    check_mask("fetch gated off again", '0, fetch_enable);
    bus_write(periph_addr(SLOT_CTRL, CTRL_EOC), 32'h1, 4'h1);
    check_word("eoc_o", 32'(1'b1), 32'(eoc));
    bus_read(periph_addr(SLOT_CTRL, CTRL_EOC), rdata);
    check_word("eoc read", 32'h1, rdata);
  endtask

  task automatic test_timer();
    logic [31:0] rdata;
    logic [31:0] prev;
    int unsigned cmp;
    int unsigned presc;
    int unsigned limit;
    int unsigned en_cycle;
    logic        seen;
    test_name = "timer";
    cmp   = lcg_next() % 6 + 3;
    presc = lcg_next() % 3 + 1;
    limit = (cmp + 1) * (presc + 1) + 4;
    bus_write(periph_addr(SLOT_TIMER, 8'(TIMER_CMP)), cmp, 4'hF);
    bus_write(periph_addr(SLOT_TIMER, 8'(TIMER_COUNT)), 32'h0, 4'hF);
    bus_write(periph_addr(SLOT_TIMER, 8'(TIMER_CFG)), (presc << 4) | 32'h1, 4'h1);
    en_cycle = xfer_cycle;
    check_word("busy_o", 32'(1'b1), 32'(busy));
    seen = 1'b0;
    while (!seen) begin
      bus_read(eu_core_addr(0, EU_BUFFER), rdata);
      if (xfer_cycle - en_cycle > limit) begin
        abort_run($sformatf("Timer event did not reach the event unit within %0d cycles",
                            limit));
      end
      seen = rdata[`EVT_TIMER_BIT];
    end
    // Counter climbs until it wraps at the compare value
    bus_read(periph_addr(SLOT_TIMER, 8'(TIMER_COUNT)), prev);
    for (int i = 0; i < 8; i++) begin
      bus_read(periph_addr(SLOT_TIMER, 8'(TIMER_COUNT)), rdata);
      if (rdata > cmp) begin
        abort_run($sformatf("Timer count %0d went past the compare value %0d", rdata, cmp));
      end
      if (rdata < prev) begin
        // A wrap only goes from the compare value back to zero
        check_word("count before wrap", cmp, prev);
        check_word("count after wrap", 32'h0, rdata);
        break;
      end
      prev = rdata;
    end
    bus_write(periph_addr(SLOT_TIMER, 8'(TIMER_CFG)), 32'h0, 4'h1);
    check_word("busy_o off", 32'(1'b0), 32'(busy));
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_write(eu_core_addr(c, EU_CLEAR), 32'h7, 4'hF);
    end
  endtask

  task automatic test_sleep_wake();
    logic [31:0]          rdata;
    int                   core;
    logic [`NB_CORES-1:0] core_bit;
    logic                 woke;
    test_name = "sleep_wake";
    core     = lcg_next() % `NB_CORES;
    core_bit = `NB_CORES'(1) << core;
    bus_write(eu_core_addr(core, EU_MASK), 32'(1) << `EVT_DMA_BIT, 4'hF);
    bus_write(eu_core_addr(core, EU_CLEAR), 32'h7, 4'hF);
    bus_write(eu_core_addr(core, EU_SLEEP), 32'h1, 4'hF);
    check_mask("clock gated", ~core_bit, core_clk_en);
    @(posedge clk);
    dma_evt <= core_bit;
    @(posedge clk);
    dma_evt <= '0;
    woke = 1'b0;
    for (int i = 0; i < 3 && !woke; i++) begin
      @(negedge clk);
      woke = core_clk_en[core];
    end
    if (!woke) begin
      abort_run($sformatf("Core %0d did not wake within 3 cycles of its DMA event", core));
    end
    check_mask("clock restored", '1, core_clk_en);
    bus_read(eu_core_addr(core, EU_BUFFER), rdata);
    check_word("buffer after DMA", 32'(1) << `EVT_DMA_BIT, rdata);
    bus_write(eu_core_addr(core, EU_CLEAR), 32'(1) << `EVT_DMA_BIT, 4'hF);
    bus_read(eu_core_addr(core, EU_BUFFER), rdata);
    check_word("buffer cleared", 32'h0, rdata);
  endtask

  task automatic test_soc_and_bus();
    logic [31:0]               rdata;
    logic [`SOC_EVT_WIDTH-1:0] data;
    logic [`PER_ID_WIDTH-1:0]  id_a;
    logic [`PER_ID_WIDTH-1:0]  id_b;
    test_name = "soc_and_bus";
    data = `SOC_EVT_WIDTH'(lcg_next());
    @(posedge clk);
    soc_evt_valid <= 1'b1;
    soc_evt_data  <= data;
    @(negedge clk);
    check_word("ready before event", 32'(1'b1), 32'(soc_evt_ready));
    @(posedge clk);
    soc_evt_valid <= 1'b0;
    @(negedge clk);
    check_word("ready after event", 32'(1'b0), 32'(soc_evt_ready));
    @(negedge clk);
    check_word("ready restored", 32'(1'b1), 32'(soc_evt_ready));
    bus_read(periph_addr(SLOT_EU, EU_SOC_DATA), rdata);
    check_word("SoC data", 32'(data), rdata);
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_read(eu_core_addr(c, EU_BUFFER), rdata);
      check_word("buffer after SoC event", 32'(1) << `EVT_SOC_BIT, rdata);
    end
    bus_read(periph_addr(SLOT_NONE, 8'h00), rdata);
    check_word("unmapped slot", `ERR_RDATA, rdata);
    // Two reads back to back, responses overlap the next request
    id_a = random_id();
    id_b = (id_a == `PER_ID_WIDTH'(1)) ? `PER_ID_WIDTH'(2) : `PER_ID_WIDTH'(1);
    @(posedge clk);
    req <= 1'b1;
    add <= boot_reg_addr(0);
    wen <= 1'b1;
    be  <= 4'hF;
    id  <= id_a;
    @(posedge clk);
    add <= boot_reg_addr(1);
    id  <= id_b;
    @(negedge clk);
    check_word("first valid", 32'(1'b1), 32'(r_valid));
    check_word("first id", 32'(id_a), 32'(r_id));
    check_word("first data", boot_model[0], r_rdata);
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_word("second valid", 32'(1'b1), 32'(r_valid));
    check_word("second id", 32'(id_b), 32'(r_id));
    check_word("second data", boot_model[1], r_rdata);
  endtask

  //************************************************************
  //******************** Sequence and watchdog *****************
  //************************************************************
  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Watchdog expired after %0d cycles before the tests finished",
                        cycle_cnt));
  end

  initial begin
    rst_n         = 1'b0;
    req           = 1'b0;
    add           = 32'h0;
    wen           = 1'b1;
    wdata         = 32'h0;
    be            = 4'h0;
    id            = '0;
    en_sa_boot    = 1'b0;
    fetch_en      = 1'b0;
    dma_evt       = '0;
    soc_evt_valid = 1'b0;
    soc_evt_data  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset_state();
    test_control_regs();
    test_timer();
    test_sleep_wake();
    test_soc_and_bus();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
